/* bench/pid_mimo_props.sv */
// register bus protocol checks
// bound into the register decoder of the PID controller

`timescale 1ns/1ps

module pid_mimo_props (
  input logic bus_i,
  input logic rstn_i,
  input logic wen_i,
  input logic ren_i,
  input logic ack_o,
  input logic err_o
);

  // ack follows any strobe by exactly one cycle
  a_ack_follows_strobe: assert property (
    @(posedge bus_i) (rstn_i && $past(rstn_i)) |-> (ack_o == $past(wen_i | ren_i))
  ) else $error("ack does not follow the strobe of the previous cycle");

  a_err_low: assert property (
    @(posedge bus_i) rstn_i |-> !err_o  // no error source exists
  ) else $error("err raised on register bus");

  // first cycle out of reset is quiet
  a_ack_after_reset: assert property (
    @(posedge bus_i) $past(!rstn_i) |-> !ack_o
  ) else $error("ack high right after reset");

endmodule

bind pid_regs pid_mimo_props i_pid_mimo_props (
  .bus_i  (bus_i),
  .rstn_i (rstn_i),
  .wen_i  (wen_i),
  .ren_i  (ren_i),
  .ack_o  (ack_o),
  .err_o  (err_o)
);

/* bench/pid_mimo_tb.sv */
// testbench for the two by two PID controller
// register access, P mixing, saturation, integrator and derivative
// outputs compared every cycle against a cycle model

`timescale 1ns/1ps

module pid_mimo_tb;
  import pid_pkg::*;

  localparam int CYC = 40;  // clock period in ns
  localparam int RUN_CYCLES = 300 + 300 + 300 + 300 + 300 + 20;  // per test budget

  logic bus = 1'b0;
  logic rstn;
  logic wen;
  logic ren;
  logic ack;
  logic err;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  dat_t dat0;
  dat_t dat1;
  dat_t dout0;
  dat_t dout1;

  // shadow settings indexed [output][input]
  int   s_sp [2][2];
  int   s_kp [2][2];
  int   s_ki [2][2];
  int   s_kd [2][2];
  logic s_irst [2][2];
  // model state
  longint m_err [2][2];
  longint m_errd [2][2];
  longint m_p [2][2];
  longint m_d [2][2];
  longint m_int [2][2];
  longint m_blk [2][2];
  longint m_out [2];

  logic [31:0] lfsr = 32'h216a;
  int   err_cnt = 0;
  int   err_mark = 0;
  int   chk_cnt = 0;
  logic chk_en = 1'b0;

  pid_mimo i_pid_mimo (
    .bus_i   (bus),
    .rstn_i  (rstn),
    .dat0_i  (dat0),
    .dat1_i  (dat1),
    .dat0_o  (dout0),
    .dat1_o  (dout1),
    .wen_i   (wen),
    .ren_i   (ren),
    .addr_i  (addr),
    .wdata_i (wdata),
    .rdata_o (rdata),
    .ack_o   (ack),
    .err_o   (err)
  );

  always #(CYC/2) bus = ~bus;

  //////////////////////////////
  // helpers

  function automatic logic lfsr_bit();  // galois lfsr with taps x^32+x^22+x^2+x+1
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  function automatic longint sat14(input longint v);
    if (v > 8191) return 8191;
    if (v < -8192) return -8192;
    return v;
  endfunction

  function automatic logic [31:0] blk_addr(input int o, input int i, input logic [3:0] ofs);
    return 32'h40 | (o << 5) | (i << 4) | ofs;
  endfunction

  // one clock of the controller rules computing new state from old
  function automatic void pid_model(input longint d0, input longint d1);
    longint s;
    for (int o = 0; o < 2; o++) m_out[o] = sat14(m_blk[o][0] + m_blk[o][1]);
    for (int o = 0; o < 2; o++) begin
      for (int i = 0; i < 2; i++) begin
        m_blk[o][i] = sat14(m_p[o][i] + (m_int[o][i] >>> ISR) + m_d[o][i]);
        s = m_int[o][i] + m_err[o][i] * s_ki[o][i];
        if (s_irst[o][i]) s = 0;
        else if (s > 64'sd2147483647) s = 64'sd2147483647;   // IW limits
        else if (s < -64'sd2147483648) s = -64'sd2147483648;
        m_int[o][i]  = s;
        m_p[o][i]    = (m_err[o][i] * s_kp[o][i]) >>> PSR;
        m_d[o][i]    = ((m_err[o][i] - m_errd[o][i]) * s_kd[o][i]) >>> DSR;
        m_errd[o][i] = m_err[o][i];
        m_err[o][i]  = s_sp[o][i] - (i == 0 ? d0 : d1);
      end
    end
  endfunction

  function automatic void model_reset();
    for (int o = 0; o < 2; o++) begin
      m_out[o] = 0;
      for (int i = 0; i < 2; i++) begin
        s_sp[o][i] = 0;
        s_kp[o][i] = 0;
        s_ki[o][i] = 0;
        s_kd[o][i] = 0;
        s_irst[o][i] = 1'b1;
        m_err[o][i] = 0;
        m_errd[o][i] = 0;
        m_p[o][i] = 0;
        m_d[o][i] = 0;
        m_int[o][i] = 0;
        m_blk[o][i] = 0;
      end
    end
  endfunction

  // register write as seen by the map
  function automatic void shadow_write(input logic [31:0] a, input logic [31:0] d);
    int o;
    int i;
    int v;
    o = a[5];
    i = a[4];
    v = int'($signed(d[13:0]));
    if (!a[6]) begin
      for (int k = 0; k < 4; k++) s_irst[k/2][k%2] = d[k];  // output major
    end else begin
      case (a[3:0])
        4'h0: s_sp[o][i] = v;
        4'h4: s_kp[o][i] = v;
        4'h8: s_ki[o][i] = v;
        4'hC: s_kd[o][i] = v;
        default: ;
      endcase
    end
  endfunction

  //////////////////////////////
  // model stepping and comparison

  always @(posedge bus) begin
    if (!rstn) begin
      model_reset();
    end else begin
      pid_model(longint'(dat0), longint'(dat1));
      if (wen) shadow_write(addr, wdata);
      chk_en = 1'b1;
    end
  end

  always @(negedge bus) begin
    if (chk_en) begin
      chk_cnt++;
      if (dout0 !== 14'(m_out[0])) begin
        $display("FAILED dat0_o got 0x%h expected 0x%h", dout0, 14'(m_out[0]));
        err_cnt++;
      end
      if (dout1 !== 14'(m_out[1])) begin
        $display("FAILED dat1_o got 0x%h expected 0x%h", dout1, 14'(m_out[1]));
        err_cnt++;
      end
      if (err !== 1'b0) begin
        $display("FAILED err_o got 0x%h expected 0x0", err);
        err_cnt++;
      end
    end
  end

  //////////////////////////////
  // bus and stimulus tasks

  task automatic wait_ack(input string what);
    int n;
    n = 0;
    while (ack !== 1'b1 && n < 8) begin
      @(negedge bus);
      n++;
    end
    if (ack !== 1'b1) begin
      $display("no acknowledge seen for %s", what);
      err_cnt++;
    end
  endtask

  task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
    @(posedge bus);
    #2;
    wen = 1'b1;
    addr = a;
    wdata = d;
    @(posedge bus);
    #2;
    wen = 1'b0;
    wait_ack("write");
  endtask

  task automatic bus_read_check(input logic [31:0] a, input logic [31:0] exp);
    @(posedge bus);
    #2;
    ren = 1'b1;
    addr = a;
    @(posedge bus);
    #2;
    ren = 1'b0;
    wait_ack("read");
    if (rdata !== exp) begin
      $display("FAILED rdata_o @0x%h got 0x%h expected 0x%h", a, rdata, exp);
      err_cnt++;
    end
  endtask

  // both outputs against a fixed expected pair
  task automatic expect_outputs(input dat_t exp0, input dat_t exp1);
    if (dout0 !== exp0) begin
      $display("FAILED dat0_o got 0x%h expected 0x%h", dout0, exp0);
      err_cnt++;
    end
    if (dout1 !== exp1) begin
      $display("FAILED dat1_o got 0x%h expected 0x%h", dout1, exp1);
      err_cnt++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge bus);
    #2;
  endtask

  task automatic set_all(input logic [3:0] ofs, input logic [13:0] v);
    for (int k = 0; k < 4; k++) bus_write(blk_addr(k/2, k%2, ofs), {18'h0, v});
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  //////////////////////////////
  // tests

  initial begin : main
    logic [13:0] vals [16];
    int pulses;
    rstn = 1'b0;
    wen = 1'b0;
    ren = 1'b0;
    addr = '0;
    wdata = '0;
    dat0 = '0;
    dat1 = '0;
    repeat (2) @(posedge bus);
    #2 rstn = 1'b1;

    // register access
    bus_read_check(32'h0, 32'hF);
    for (int k = 0; k < 16; k++) bus_read_check(blk_addr(k/8, (k/4)%2, 4'(4*(k%4))), 32'h0);
    for (int k = 0; k < 16; k++) begin
      vals[k] = 14'(rnd(14));
      bus_write(blk_addr(k/8, (k/4)%2, 4'(4*(k%4))), {18'h0, vals[k]});
    end
    for (int k = 0; k < 16; k++)
      bus_read_check(blk_addr(k/8, (k/4)%2, 4'(4*(k%4))), {18'h0, vals[k]});
    for (int k = 0; k < 4; k++) set_all(4'(4*k), 14'h0);
    end_test("register access");

    // proportional mixing
    for (int k = 0; k < 4; k++) bus_write(blk_addr(k/2, k%2, REG_KP), rnd(14));
    repeat (80) begin
      @(posedge bus);
      #2;
      dat0 = 14'(rnd(14));
      dat1 = 14'(rnd(14));
    end
    idle(6);
    end_test("proportional mixing");

    // saturation at both rails
    set_all(REG_KP, 14'h1FFF);
    dat0 = 14'h2000;
    dat1 = 14'h2000;
    idle(8);
    expect_outputs(14'h1FFF, 14'h1FFF);
    dat0 = 14'h1FFF;
    dat1 = 14'h1FFF;
    idle(8);
    expect_outputs(14'h2000, 14'h2000);
    end_test("saturation");

    // integrator ramp then release
    set_all(REG_KP, 14'h0);
    set_all(REG_KI, 14'h1FFF);
    dat0 = -14'sd100;  // constant error of 100
    dat1 = -14'sd100;
    idle(4);
    bus_write(32'h0, 32'h0);
    idle(40);
    if ($signed(dout0) <= 0 || $signed(dout1) <= 0) begin
      $display("integrator output did not ramp up");
      err_cnt++;
    end
    bus_write(32'h0, 32'hF);
    idle(8);
    expect_outputs(14'h0, 14'h0);
    end_test("integrator");

    // derivative pulse on a step of input 0
    set_all(REG_KI, 14'h0);
    set_all(REG_KD, 14'h1000);
    dat0 = '0;
    dat1 = '0;
    idle(8);
    dat0 = 14'sd1000;
    pulses = 0;
    repeat (10) begin
      @(negedge bus);
      if (dout0 !== 14'h0) begin
        pulses++;
        if (dout0 !== 14'(-4000)) begin  // -1000 * 4096 >>> 10
          $display("FAILED dat0_o pulse got 0x%h expected 0x%h", dout0, 14'(-4000));
          err_cnt++;
        end
      end
    end
    if (pulses != 1) begin
      $display("derivative gave %0d nonzero output cycles instead of one", pulses);
      err_cnt++;
    end
    end_test("derivative");

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(RUN_CYCLES * CYC);
    $display("watchdog expired before the tests finished");
    $display("Test FAILED");
    $finish;
  end

endmodule

/* logic/pid_block.sv */
// single PID controller
// error against setpoint, then P, I and D terms,
// then the saturated 14 bit sum, three cycles in all

`timescale 1ns/1ps

module pid_block #(
  parameter int unsigned OI = 0,  // output index
  parameter int unsigned II = 0   // input index
) (
  input  logic          bus_i,
  input  logic          rstn_i,
  input  pid_pkg::dat_t dat_i,
  pid_cfg_if.pid        cfg,
  output pid_pkg::dat_t dat_o
);
  import pid_pkg::*;

  // settings of this block
  cfg_t sp;
  cfg_t kp;
  cfg_t ki;
  cfg_t kd;
  logic irst;

  logic signed [DW:0]           err;      // current error
  logic signed [DW:0]           err_d;    // error one sample back
  logic signed [DW+1:0]         err_dif;  // error difference
  logic signed [DW+CW:0]        p_mul;
  logic signed [DW+CW:0]        i_mul;
  logic signed [DW+CW+1:0]      d_mul;
  logic signed [DW+CW-PSR:0]    p_trm;
  logic signed [DW+CW+1-DSR:0]  d_trm;
  logic signed [IW-1:0]         int_reg;  // integrator
  logic signed [IW:0]           int_sum;
  logic signed [IW-ISR-1:0]     i_trm;
  logic signed [DW+CW-DSR+3:0]  pid_sum;

  assign sp   = cfg.sp[OI][II];
  assign kp   = cfg.kp[OI][II];
  assign ki   = cfg.ki[OI][II];
  assign kd   = cfg.kd[OI][II];
  assign irst = cfg.irst[OI][II];

  //////////////////////////////
  // stage 1 error

  always_ff @(posedge bus_i) begin
    if (!rstn_i) begin
      err   <= '0;
      err_d <= '0;
    end else begin
      err   <= (DW+1)'(sp) - (DW+1)'(dat_i);
      err_d <= err;  // kept for the derivative
    end
  end

  //////////////////////////////
  // stage 2 terms

  // full width signed products
  assign p_mul   = (DW+CW+1)'(err) * (DW+CW+1)'(kp);
  assign i_mul   = (DW+CW+1)'(err) * (DW+CW+1)'(ki);
  assign err_dif = (DW+2)'(err) - (DW+2)'(err_d);
  assign d_mul   = (DW+CW+2)'(err_dif) * (DW+CW+2)'(kd);

  // one guard bit to catch integrator overflow
  assign int_sum = (IW+1)'(int_reg) + (IW+1)'(i_mul);

  always_ff @(posedge bus_i) begin
    if (!rstn_i) begin
      p_trm <= '0;
      d_trm <= '0;
    end else begin
      p_trm <= p_mul[DW+CW:PSR];      // drop PSR fraction bits
      d_trm <= d_mul[DW+CW+1:DSR];
    end
  end

  always_ff @(posedge bus_i) begin
    if (!rstn_i) begin
      int_reg <= '0;
    end else if (irst) begin
      int_reg <= '0;                  // held while reset bit set
    end else if (int_sum[IW:IW-1] == 2'b01) begin
      int_reg <= {1'b0, {(IW-1){1'b1}}};  // clamp high
    end else if (int_sum[IW:IW-1] == 2'b10) begin
      int_reg <= {1'b1, {(IW-1){1'b0}}};  // clamp low
    end else begin
      int_reg <= int_sum[IW-1:0];
    end
  end

  // integrator top bits are the I term
  assign i_trm = int_reg[IW-1:ISR];

  //////////////////////////////
  // stage 3 sum and saturation

  assign pid_sum = (DW+CW-DSR+4)'(p_trm)
                 + (DW+CW-DSR+4)'(i_trm)
                 + (DW+CW-DSR+4)'(d_trm);

  always_ff @(posedge bus_i) begin
    if (!rstn_i) begin
      dat_o <= '0;
    end else if (!pid_sum[DW+CW-DSR+3] && (|pid_sum[DW+CW-DSR+2:DW-1])) begin
      dat_o <= DAT_MAX;   // positive overflow
    end else if (pid_sum[DW+CW-DSR+3] && !(&pid_sum[DW+CW-DSR+2:DW-1])) begin
      dat_o <= DAT_MIN;   // negative overflow
    end else begin
      dat_o <= pid_sum[DW-1:0];
    end
  end

endmodule

/* logic/pid_cfg_if.sv */
// PID settings bundle
// carries setpoint, gains and integrator reset
// from the register decoder to the four PID blocks

`timescale 1ns/1ps

interface pid_cfg_if;
  import pid_pkg::*;

  // indexed as [output][input]
  cfg_t [CNO-1:0][CNI-1:0] sp;    // setpoint
  cfg_t [CNO-1:0][CNI-1:0] kp;    // proportional gain
  cfg_t [CNO-1:0][CNI-1:0] ki;    // integral gain
  cfg_t [CNO-1:0][CNI-1:0] kd;    // derivative gain
  logic [CNO-1:0][CNI-1:0] irst;  // integrator held at zero while set

  // register side
  modport regs (
    output sp, kp, ki, kd, irst
  );

  // controller side
  modport pid (
    input sp, kp, ki, kd, irst
  );

endinterface

/* logic/pid_mimo.sv */
// two input, two output PID controller
// register decoder, four PID blocks and the output mixer
// four cycles from sample in to sample out

`timescale 1ns/1ps

module pid_mimo (
  input  logic          bus_i,    // single clock for stream and bus
  input  logic          rstn_i,
  // sample streams
  input  pid_pkg::dat_t dat0_i,
  input  pid_pkg::dat_t dat1_i,
  output pid_pkg::dat_t dat0_o,
  output pid_pkg::dat_t dat1_o,
  // register bus
  input  logic          wen_i,
  input  logic          ren_i,
  input  logic [31:0]   addr_i,
  input  logic [31:0]   wdata_i,
  output logic [31:0]   rdata_o,
  output logic          ack_o,
  output logic          err_o
);
  import pid_pkg::*;

  dat_t [CNI-1:0]          dat_in;   // inputs as array
  dat_t [CNO-1:0][CNI-1:0] blk_dat;  // per block results
  dat_t [CNO-1:0]          dat_out;  // mixed outputs

  assign dat_in = {dat1_i, dat0_i};

  pid_cfg_if cfg ();

  //////////////////////////////
  // decode

  pid_regs i_pid_regs (
    .bus_i   (bus_i),
    .rstn_i  (rstn_i),
    .wen_i   (wen_i),
    .ren_i   (ren_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .rdata_o (rdata_o),
    .ack_o   (ack_o),
    .err_o   (err_o),
    .cfg     (cfg)
  );

  //////////////////////////////
  // execute

  // every input feeds one block per output
  for (genvar o = 0; o < CNO; o++) begin : g_out
    for (genvar i = 0; i < CNI; i++) begin : g_in
      pid_block #(
        .OI (o),
        .II (i)
      ) i_pid_block (
        .bus_i  (bus_i),
        .rstn_i (rstn_i),
        .dat_i  (dat_in[i]),
        .cfg    (cfg),
        .dat_o  (blk_dat[o][i])
      );
    end
  end

  //////////////////////////////
  // result

  pid_mix i_pid_mix (
    .bus_i     (bus_i),
    .rstn_i    (rstn_i),
    .blk_dat_i (blk_dat),
    .dat_o     (dat_out)
  );

  assign dat0_o = dat_out[0];
  assign dat1_o = dat_out[1];

endmodule

/* logic/pid_mix.sv */
// PID output mixer
// adds the results of the blocks feeding each output
// and saturates the sum back to 14 bits

`timescale 1ns/1ps

module pid_mix (
  input  logic          bus_i,
  input  logic          rstn_i,
  input  pid_pkg::dat_t [pid_pkg::CNO-1:0][pid_pkg::CNI-1:0] blk_dat_i,
  output pid_pkg::dat_t [pid_pkg::CNO-1:0]                   dat_o
);
  import pid_pkg::*;

  logic signed [DW:0] sum [CNO];  // one spare bit per output

  // sum over inputs for each output
  always_comb begin
    for (int o = 0; o < CNO; o++) begin
      sum[o] = '0;
      for (int i = 0; i < CNI; i++) begin
        sum[o] = sum[o] + (DW+1)'(blk_dat_i[o][i]);
      end
    end
  end

  // top two bits disagree on overflow
  always_ff @(posedge bus_i) begin
    if (!rstn_i) begin
      dat_o <= '0;
    end else begin
      for (int o = 0; o < CNO; o++) begin
        if (sum[o][DW:DW-1] == 2'b01) begin
          dat_o[o] <= DAT_MAX;
        end else if (sum[o][DW:DW-1] == 2'b10) begin
          dat_o[o] <= DAT_MIN;
        end else begin
          dat_o[o] <= sum[o][DW-1:0];
        end
      end
    end
  end

endmodule

/* logic/pid_pkg.sv */
// MIMO PID controller shared definitions
// sample and setting widths, product shifts, register map
// and the two views of the register bus address

package pid_pkg;

  //////////////////////////////
  // sizes
  localparam int unsigned DW  = 14;  // sample width
  localparam int unsigned CW  = 14;  // signed setting width
  localparam int unsigned CNI = 2;   // input channels
  localparam int unsigned CNO = 2;   // output channels

  // right shifts on the gain products
  localparam int unsigned PSR = 12;
  localparam int unsigned ISR = 18;
  localparam int unsigned DSR = 10;
  localparam int unsigned IW  = 32;  // integrator width

  typedef logic signed [DW-1:0] dat_t;  // stream sample
  typedef logic signed [CW-1:0] cfg_t;  // gain or setpoint

  // saturation limits for a 14 bit sample
  localparam dat_t DAT_MAX = 14'h1FFF;
  localparam dat_t DAT_MIN = 14'h2000;

  //////////////////////////////
  // register map
  localparam logic [3:0] REG_SP = 4'h0;  // setpoint
  localparam logic [3:0] REG_KP = 4'h4;  // proportional gain
  localparam logic [3:0] REG_KI = 4'h8;  // integral gain
  localparam logic [3:0] REG_KD = 4'hC;  // derivative gain

  // bus address seen as global page or as block window
  typedef union packed {
    struct packed {
      logic [31:7] rsv_h;
      logic        page;   // 0 selects integrator reset bits
      logic [5:0]  rsv_l;
    } glb;
    struct packed {
      logic [31:7] rsv;
      logic        page;   // 1 selects block settings
      logic        oi;     // output index
      logic        ii;     // input index
      logic [3:0]  ofs;    // register inside the 16 byte window
    } blk;
  } pid_addr_u;

endpackage

/* logic/pid_regs.sv */
// PID register decoder
// holds setpoints, gains and integrator reset bits for all blocks
// strobe based bus with one cycle read latency and ack pulse

`timescale 1ns/1ps

module pid_regs (
  input  logic        bus_i,    // bus clock
  input  logic        rstn_i,   // sync reset active low
  input  logic        wen_i,    // write strobe
  input  logic        ren_i,    // read strobe
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  output logic        ack_o,
  output logic        err_o,
  pid_cfg_if.regs     cfg
);
  import pid_pkg::*;

  //////////////////////////////
  // address decode

  pid_addr_u adr;   // two views of addr_i
  cfg_t      rd_set;  // selected setting for readback

  assign adr = addr_i;

  //////////////////////////////
  // settings write

  always_ff @(posedge bus_i) begin
    if (!rstn_i) begin
      cfg.sp   <= '0;
      cfg.kp   <= '0;
      cfg.ki   <= '0;
      cfg.kd   <= '0;
      cfg.irst <= '1;  // integrators parked at zero
    end else if (wen_i) begin
      if (!adr.glb.page) begin
        // one reset bit per block in output major order
        cfg.irst <= wdata_i[CNO*CNI-1:0];
      end else begin
        case (adr.blk.ofs)
          REG_SP: cfg.sp[adr.blk.oi][adr.blk.ii] <= wdata_i[CW-1:0];
          REG_KP: cfg.kp[adr.blk.oi][adr.blk.ii] <= wdata_i[CW-1:0];
          REG_KI: cfg.ki[adr.blk.oi][adr.blk.ii] <= wdata_i[CW-1:0];
          REG_KD: cfg.kd[adr.blk.oi][adr.blk.ii] <= wdata_i[CW-1:0];
          default: ;  // unaligned offsets ignored
        endcase
      end
    end
  end

  //////////////////////////////
  // read mux

  // pick the addressed setting of the addressed block
  always_comb begin
    case (adr.blk.ofs)
      REG_SP:  rd_set = cfg.sp[adr.blk.oi][adr.blk.ii];
      REG_KP:  rd_set = cfg.kp[adr.blk.oi][adr.blk.ii];
      REG_KI:  rd_set = cfg.ki[adr.blk.oi][adr.blk.ii];
      REG_KD:  rd_set = cfg.kd[adr.blk.oi][adr.blk.ii];
      default: rd_set = '0;
    endcase
  end

  // data lands together with the ack pulse
  always_ff @(posedge bus_i) begin
    if (!rstn_i) begin
      rdata_o <= '0;
    end else if (ren_i) begin
      if (!adr.glb.page) begin
        rdata_o <= {{(32-CNO*CNI){1'b0}}, cfg.irst};
      end else begin
        rdata_o <= {{(32-CW){1'b0}}, rd_set};  // zero extended
      end
    end
  end

  //////////////////////////////
  // bus response

  always_ff @(posedge bus_i) begin
    if (!rstn_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      ack_o <= wen_i | ren_i;  // one pulse per strobe
      err_o <= 1'b0;           // no error conditions
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the PID controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -f sim.f \
  --top-module pid_mimo_tb -o pid_sim > build.log 2>&1 &&
  ./obj_dir/pid_sim > sim.log 2>&1 ||
  { echo "build or simulation error, see build.log and sim.log"; exit 1; }

if grep -q "Test FAILED" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi
exit 0

/* sim.f */
logic/pid_pkg.sv
logic/pid_cfg_if.sv
logic/pid_regs.sv
logic/pid_block.sv
logic/pid_mix.sv
logic/pid_mimo.sv
bench/pid_mimo_props.sv
bench/pid_mimo_tb.sv
